// File: all.f
+incdir+verification
verilog/cast_fmt_pkg.sv
verilog/cast_op_pkg.sv
verilog/cast_rounder.sv
verilog/cast_f2i.sv
verilog/cast_i2f.sv
verilog/cast_result_stage.sv
verilog/cast_unit_top.sv
verification/cast_unit_tb.sv

// File: verification/cast_unit_tb_vectors.svh
// ----------------------------
// cast unit test vectors
// F2I and I2F rows with expected result and flags
// ----------------------------

`ifndef CAST_UNIT_TB_VECTORS_SVH
`define CAST_UNIT_TB_VECTORS_SVH

localparam int NUM_VECTORS = 34;

// columns: op, unsigned, mode, operand, expected result, expected nv, expected nx
task automatic load_vectors();
  // ----------------------------
  // F2I regular values
  // ----------------------------
  add_vector(OP_F2I, 1'b0, RNE, 32'h4020_0000, 32'h0000_0002, 1'b0, 1'b1); // 2.5
  add_vector(OP_F2I, 1'b0, RTZ, 32'h4020_0000, 32'h0000_0002, 1'b0, 1'b1);
  add_vector(OP_F2I, 1'b0, RUP, 32'h4020_0000, 32'h0000_0003, 1'b0, 1'b1);
  add_vector(OP_F2I, 1'b0, RMM, 32'h4020_0000, 32'h0000_0003, 1'b0, 1'b1);
  add_vector(OP_F2I, 1'b0, RDN, 32'hC020_0000, 32'hFFFF_FFFD, 1'b0, 1'b1); // -2.5 to -3
  add_vector(OP_F2I, 1'b0, RNE, 32'hC020_0000, 32'hFFFF_FFFE, 1'b0, 1'b1); // tie to even
  add_vector(OP_F2I, 1'b0, RNE, 32'h3F80_0000, 32'h0000_0001, 1'b0, 1'b0); // 1.0 exact
  add_vector(OP_F2I, 1'b0, RNE, 32'h3FC0_0000, 32'h0000_0002, 1'b0, 1'b1); // 1.5
  add_vector(OP_F2I, 1'b0, RNE, 32'h3F00_0000, 32'h0000_0000, 1'b0, 1'b1); // 0.5
  // ----------------------------
  // F2I saturation and invalid
  // ----------------------------
  add_vector(OP_F2I, 1'b0, RNE, 32'h7FC0_0000, 32'h7FFF_FFFF, 1'b1, 1'b0); // qnan
  add_vector(OP_F2I, 1'b1, RNE, 32'h7FC0_0000, 32'hFFFF_FFFF, 1'b1, 1'b0);
  add_vector(OP_F2I, 1'b0, RNE, 32'hFFC0_0000, 32'h7FFF_FFFF, 1'b1, 1'b0); // nan sign ignored
  add_vector(OP_F2I, 1'b0, RNE, 32'h7F80_0000, 32'h7FFF_FFFF, 1'b1, 1'b0); // +inf
  add_vector(OP_F2I, 1'b0, RNE, 32'hFF80_0000, 32'h8000_0000, 1'b1, 1'b0); // -inf
  add_vector(OP_F2I, 1'b1, RNE, 32'hFF80_0000, 32'h0000_0000, 1'b1, 1'b0);
  add_vector(OP_F2I, 1'b0, RNE, 32'h4F32_D05E, 32'h7FFF_FFFF, 1'b1, 1'b0); // 3.0e9
  add_vector(OP_F2I, 1'b1, RNE, 32'h4F32_D05E, 32'hB2D0_5E00, 1'b0, 1'b0); // fits unsigned
  add_vector(OP_F2I, 1'b0, RTZ, 32'hCF00_0000, 32'h8000_0000, 1'b0, 1'b0); // -2**31
  add_vector(OP_F2I, 1'b1, RNE, 32'hBF80_0000, 32'h0000_0000, 1'b1, 1'b0); // -1.0
  add_vector(OP_F2I, 1'b1, RTZ, 32'hBE80_0000, 32'h0000_0000, 1'b0, 1'b1); // -0.25 to zero
  add_vector(OP_F2I, 1'b1, RDN, 32'hBE80_0000, 32'h0000_0000, 1'b1, 1'b0); // -0.25 to -1
  add_vector(OP_F2I, 1'b1, RNE, 32'h8000_0000, 32'h0000_0000, 1'b0, 1'b0); // -0.0
  add_vector(OP_F2I, 1'b0, RUP, 32'h0000_0001, 32'h0000_0001, 1'b0, 1'b1); // subnormal
  // ----------------------------
  // I2F
  // ----------------------------
  add_vector(OP_I2F, 1'b0, RNE, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0);
  add_vector(OP_I2F, 1'b0, RNE, 32'hFFFF_FFFF, 32'hBF80_0000, 1'b0, 1'b0); // -1
  add_vector(OP_I2F, 1'b1, RNE, 32'hFFFF_FFFF, 32'h4F80_0000, 1'b0, 1'b1); // up to 2**32
  add_vector(OP_I2F, 1'b1, RTZ, 32'hFFFF_FFFF, 32'h4F7F_FFFF, 1'b0, 1'b1);
  add_vector(OP_I2F, 1'b0, RNE, 32'h0100_0001, 32'h4B80_0000, 1'b0, 1'b1); // 16777217
  add_vector(OP_I2F, 1'b0, RUP, 32'h0100_0001, 32'h4B80_0001, 1'b0, 1'b1);
  add_vector(OP_I2F, 1'b0, RNE, 32'h0100_0003, 32'h4B80_0002, 1'b0, 1'b1); // tie, odd lsb
  add_vector(OP_I2F, 1'b0, RDN, 32'hFEFF_FFFF, 32'hCB80_0001, 1'b0, 1'b1); // -16777217
  add_vector(OP_I2F, 1'b0, RNE, 32'h8000_0000, 32'hCF00_0000, 1'b0, 1'b0); // int min
  add_vector(OP_I2F, 1'b1, RNE, 32'h0000_0007, 32'h40E0_0000, 1'b0, 1'b0);
  add_vector(OP_I2F, 1'b0, RMM, 32'h7FFF_FFFF, 32'h4F00_0000, 1'b0, 1'b1); // int max
endtask

`endif

// File: verification/cast_unit_tb.sv
// ----------------------------
// cast unit testbench
// table driven F2I/I2F checks with random
// idle cycles and output back-pressure
// ----------------------------

`default_nettype none

module cast_unit_tb
  import cast_op_pkg::*;
();

  localparam logic [31:0] LFSR_SEED      = 32'hc379_7208;
  localparam int          ACCEPT_TIMEOUT = 100; // cycles per input handshake
  localparam int          OUTPUT_TIMEOUT = 100; // cycles without an output

  `include "cast_unit_tb_vectors.svh"

  logic        clk, rst_n;
  logic [31:0] operand;
  cast_op_e    op;
  logic        int_unsigned;
  round_mode_e rnd_mode;
  logic        in_valid, in_ready, out_valid, out_ready;
  logic [31:0] result;
  logic        flag_nv, flag_nx;

  // expected value table filled by load_vectors
  cast_op_e    vec_op       [NUM_VECTORS];
  logic        vec_unsigned [NUM_VECTORS];
  round_mode_e vec_mode     [NUM_VECTORS];
  logic [31:0] vec_operand  [NUM_VECTORS];
  logic [31:0] vec_result   [NUM_VECTORS];
  logic        vec_nv       [NUM_VECTORS];
  logic        vec_nx       [NUM_VECTORS];
  int          num_loaded, rows_checked, value_errors, timeout_errors;
  logic [31:0] drive_lfsr, ready_lfsr; // idle gaps and out_ready streams

  always #5 clk = ~clk;

  cast_unit_top u_dut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .operand_i      (operand),
    .op_i           (op),
    .int_unsigned_i (int_unsigned),
    .rnd_mode_i     (rnd_mode),
    .in_valid_i     (in_valid),
    .in_ready_o     (in_ready),
    .out_valid_o    (out_valid),
    .out_ready_i    (out_ready),
    .result_o       (result),
    .flag_nv_o      (flag_nv),
    .flag_nx_o      (flag_nx)
  );

  // ----------------------------
  // helpers
  // ----------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    lfsr_next = (state >> 1) ^ (state[0] ? 32'h8020_0003 : 32'h0); // galois with taps 32 22 2 1
  endfunction

  task automatic draw_bits(inout logic [31:0] state, input int count, output int bits);
    bits = 0;
    repeat (count) begin
      state = lfsr_next(state);
      bits  = (bits << 1) | state[0];
    end
  endtask

  task automatic add_vector(input cast_op_e op_v, input logic uns_v, input round_mode_e mode_v,
                            input logic [31:0] operand_v, input logic [31:0] result_v,
                            input logic nv_v, input logic nx_v);
    vec_op[num_loaded]       = op_v;
    vec_unsigned[num_loaded] = uns_v;
    vec_mode[num_loaded]     = mode_v;
    vec_operand[num_loaded]  = operand_v;
    vec_result[num_loaded]   = result_v;
    vec_nv[num_loaded]       = nv_v;
    vec_nx[num_loaded]       = nx_v;
    num_loaded++;
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      value_errors++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  // ----------------------------
  // input side
  // ----------------------------
  task automatic send_rows();
    int   idle;
    int   waited;
    logic accepted;
    for (int i = 0; i < NUM_VECTORS; i++) begin
      draw_bits(drive_lfsr, 2, idle); // 0..3 idle cycles
      repeat (idle) @(negedge clk);
      in_valid     = 1'b1;
      op           = vec_op[i];
      int_unsigned = vec_unsigned[i];
      rnd_mode     = vec_mode[i];
      operand      = vec_operand[i];
      waited       = 0;
      accepted     = 1'b0;
      while (!accepted && waited < ACCEPT_TIMEOUT) begin
        @(posedge clk);
        accepted = in_ready; // sampled before the edge takes effect
        waited++;
      end
      if (!accepted) begin
        timeout_errors++;
        $display("timeout: row %0d was not accepted by the DUT", i);
        break;
      end
      @(negedge clk);
      in_valid = 1'b0;
      check_value($sformatf("row %0d out_valid_o one cycle after accept", i), out_valid, 1);
    end
  endtask

  // ----------------------------
  // output side
  // ----------------------------
  task automatic collect_results();
    int          ready_bits;
    int          quiet_cycles;
    logic        held;         // stalled at the last edge so it must hold
    logic [31:0] held_result;
    logic [1:0]  held_flags;
    held         = 1'b0;
    quiet_cycles = 0;
    while (rows_checked < NUM_VECTORS && quiet_cycles < OUTPUT_TIMEOUT) begin
      @(negedge clk);
      draw_bits(ready_lfsr, 2, ready_bits);
      out_ready = (ready_bits != 0); // stall about one cycle in four
      @(posedge clk);
      if (held) begin
        check_value("out_valid_o under back-pressure", out_valid, 1);
        check_value("result_o under back-pressure", result, held_result);
        check_value("flags under back-pressure", {flag_nv, flag_nx}, held_flags);
      end
      held        = out_valid & ~out_ready;
      held_result = result;
      held_flags  = {flag_nv, flag_nx};
      if (held) begin
        check_value("in_ready_o under back-pressure", in_ready, 0); // full and not draining
      end
      if (out_valid && out_ready) begin
        check_value($sformatf("row %0d result_o", rows_checked), result,
                    vec_result[rows_checked]);
        check_value($sformatf("row %0d flag_nv_o", rows_checked), flag_nv, vec_nv[rows_checked]);
        check_value($sformatf("row %0d flag_nx_o", rows_checked), flag_nx, vec_nx[rows_checked]);
        rows_checked++;
        quiet_cycles = 0;
      end else begin
        quiet_cycles++;
      end
    end
    if (rows_checked < NUM_VECTORS) begin
      timeout_errors++;
      $display("timeout: only %0d results came out of the DUT", rows_checked);
    end
  endtask

  // ----------------------------
  // main sequence
  // ----------------------------
  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    operand        = '0;
    op             = OP_F2I;
    int_unsigned   = 1'b0;
    rnd_mode       = RNE;
    in_valid       = 1'b0;
    out_ready      = 1'b0;
    num_loaded     = 0;
    rows_checked   = 0;
    value_errors   = 0;
    timeout_errors = 0;
    drive_lfsr     = LFSR_SEED;
    ready_lfsr     = LFSR_SEED;
    load_vectors();
    check_value("number of table rows", num_loaded, NUM_VECTORS);
    repeat (10) begin
      @(posedge clk);
      check_value("out_valid_o in reset", out_valid, 0);
    end
    @(negedge clk);
    rst_n = 1'b1;
    check_value("out_valid_o after reset", out_valid, 0);
    check_value("result_o after reset", result, 0);
    check_value("flags after reset", {flag_nv, flag_nx}, 0);
    fork
      send_rows();
      collect_results();
    join
    $display("%0d of %0d rows checked, %0d value errors, %0d timeouts",
             rows_checked, NUM_VECTORS, value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/cast_f2i.sv
// ----------------------------
// FP32 to integer converter
// shifts the mantissa into integer position, rounds,
// saturates out of range and NaN inputs with NV
// ----------------------------

`default_nettype none

module cast_f2i
  import cast_fmt_pkg::*;
  import cast_op_pkg::*;
(
  input  logic [FP_WIDTH-1:0]  operand_i,
  input  logic                 int_unsigned_i, // unsigned destination
  input  round_mode_e          rnd_mode_i,
  output logic [INT_WIDTH-1:0] result_o,
  output logic                 nv_o,
  output logic                 nx_o
);

  // ----------------------------
  // classification
  // ----------------------------
  logic                            sign;
  logic [EXP_BITS-1:0]             exp_field;
  logic [MAN_BITS-1:0]             man_field;
  logic                            exp_zero, exp_ones, man_zero;
  logic                            is_sub, is_inf, is_nan;
  logic signed [INT_EXP_WIDTH-1:0] input_exp; // unbiased

  assign sign      = operand_i[FP_WIDTH-1];
  assign exp_field = operand_i[MAN_BITS +: EXP_BITS];
  assign man_field = operand_i[MAN_BITS-1:0];

  assign exp_zero = (exp_field == '0);
  assign exp_ones = (exp_field == QNAN[MAN_BITS +: EXP_BITS]); // nan/inf exponent
  assign man_zero = (man_field == '0);

  assign is_sub = exp_zero & ~man_zero;
  assign is_inf = exp_ones & man_zero;
  assign is_nan = exp_ones & ~man_zero;

  // subnormals sit at exponent 1 without hidden bit
  assign input_exp = INT_EXP_WIDTH'(exp_field) + INT_EXP_WIDTH'(is_sub)
                   - INT_EXP_WIDTH'(BIAS);

  // ----------------------------
  // shift into integer position
  // ----------------------------
  logic [LZC_WIDTH:0]     shamt;           // 0..33
  logic                   of_before_round; // |value| >= 2**32
  logic [2*INT_WIDTH-1:0] preshift_mant;   // hidden bit at the top
  logic [2*INT_WIDTH-1:0] shifted_mant;
  logic [INT_WIDTH-1:0]   int_field;
  logic [1:0]             round_sticky;

  always_comb begin
    shamt           = '0;
    of_before_round = 1'b0;
    if (input_exp >= INT_WIDTH) begin
      of_before_round = 1'b1; // also covers inf and nan
    end else if (input_exp < -1) begin
      shamt = (LZC_WIDTH + 1)'(INT_WIDTH + 1); // whole mantissa lands in sticky
    end else begin
      shamt = (LZC_WIDTH + 1)'(INT_WIDTH - 1 - input_exp);
    end
  end

  assign preshift_mant = {~exp_zero, man_field, {(2*INT_WIDTH-MAN_BITS-1){1'b0}}};
  assign shifted_mant  = preshift_mant >> shamt;

  // upper half integer, then round bit, rest is sticky
  assign int_field       = shifted_mant[2*INT_WIDTH-1 -: INT_WIDTH];
  assign round_sticky[1] = shifted_mant[INT_WIDTH-1];
  assign round_sticky[0] = |shifted_mant[INT_WIDTH-2:0];

  // ----------------------------
  // rounding
  // ----------------------------
  logic [INT_WIDTH-1:0] rounded_abs;
  logic                 carry;

  cast_rounder u_rounder (
    .abs_value_i    (int_field),
    .sign_i         (sign),
    .round_sticky_i (round_sticky),
    .rnd_mode_i     (rnd_mode_i),
    .abs_rounded_o  (rounded_abs),
    .carry_o        (carry)
  );

  // ----------------------------
  // range check and saturation
  // ----------------------------
  logic                 of_after_round;
  logic                 neg_unsigned; // negative value, nonzero after rounding
  logic                 is_special;
  logic [INT_WIDTH-1:0] sat_pos;      // 7fffffff or ffffffff
  logic [INT_WIDTH-1:0] special_res;
  logic [INT_WIDTH-1:0] rounded_int;

  always_comb begin
    if (int_unsigned_i) begin
      of_after_round = carry;
    end else if (!sign) begin
      of_after_round = carry | rounded_abs[INT_WIDTH-1]; // above 2**31-1
    end else begin
      // exactly 2**31 is still -2**31
      of_after_round = carry | (rounded_abs[INT_WIDTH-1] & (|rounded_abs[INT_WIDTH-2:0]));
    end
  end

  assign neg_unsigned = sign & int_unsigned_i & (carry | (|rounded_abs));
  assign is_special   = is_nan | is_inf | of_before_round | of_after_round | neg_unsigned;

  assign sat_pos     = {int_unsigned_i, {(INT_WIDTH-1){1'b1}}};
  assign special_res = (sign & ~is_nan) ? ~sat_pos : sat_pos; // negatives to min or 0
  assign rounded_int = sign ? -rounded_abs : rounded_abs;

  assign result_o = is_special ? special_res : rounded_int;
  assign nv_o     = is_special;
  assign nx_o     = ~is_special & (|round_sticky);

endmodule

`default_nettype wire

// File: verilog/cast_fmt_pkg.sv
// ----------------------------
// cast format package
// field layout of FP32 and INT32, shared by
// both converters and the result stage
// ----------------------------

`default_nettype none

package cast_fmt_pkg;

  // ----------------------------
  // FP32 encoding
  // ----------------------------
  localparam int FP_WIDTH = 32;  // full word
  localparam int EXP_BITS = 8;   // exponent field
  localparam int MAN_BITS = 23;  // stored mantissa, no hidden bit
  localparam int BIAS     = 127; // 2**(EXP_BITS-1) - 1

  // canonical quiet NaN, exponent all ones and quiet bit set
  localparam logic [FP_WIDTH-1:0] QNAN = 32'h7FC0_0000;

  // ----------------------------
  // integer side
  // ----------------------------
  localparam int INT_WIDTH = 32;

  // signed unbiased exponent, covers -126..+127 plus lzc range
  localparam int INT_EXP_WIDTH = 10;

  // leading zero count over INT_WIDTH bits
  localparam int LZC_WIDTH = 5;

endpackage

`default_nettype wire

// File: verilog/cast_i2f.sv
// ----------------------------
// integer to FP32 converter
// normalizes the magnitude by leading zero count
// and rounds the dropped low bits
// ----------------------------

`default_nettype none

module cast_i2f
  import cast_fmt_pkg::*;
  import cast_op_pkg::*;
(
  input  logic [INT_WIDTH-1:0] operand_i,
  input  logic                 int_unsigned_i, // unsigned source
  input  round_mode_e          rnd_mode_i,
  output logic [FP_WIDTH-1:0]  result_o,
  output logic                 nx_o
);

  // ----------------------------
  // magnitude
  // ----------------------------
  logic                 int_sign;
  logic [INT_WIDTH-1:0] abs_val;
  logic                 val_zero;

  assign int_sign = operand_i[INT_WIDTH-1] & ~int_unsigned_i; // only signed can be negative
  assign abs_val  = int_sign ? -operand_i : operand_i;        // 80000000 stays as is
  assign val_zero = (abs_val == '0);

  // ----------------------------
  // normalization
  // ----------------------------
  logic [LZC_WIDTH-1:0] lz_cnt;
  logic [INT_WIDTH-1:0] norm_val;   // leading one at msb
  logic [EXP_BITS-1:0]  biased_exp;

  // highest set bit wins, later iterations overwrite
  always_comb begin
    lz_cnt = '0;
    for (int i = 0; i < INT_WIDTH; i++) begin
      if (abs_val[i]) begin
        lz_cnt = LZC_WIDTH'(INT_WIDTH - 1 - i);
      end
    end
  end

  assign norm_val   = abs_val << lz_cnt;
  assign biased_exp = EXP_BITS'(BIAS + INT_WIDTH - 1) - EXP_BITS'(lz_cnt); // 127..158

  // ----------------------------
  // pack and round
  // ----------------------------
  logic [INT_WIDTH-1:0] pre_round;
  logic [INT_WIDTH-1:0] rounded_abs;
  logic [1:0]           round_sticky;

  // hidden bit dropped, top 23 bits after it form the mantissa
  assign pre_round = {1'b0, biased_exp, norm_val[INT_WIDTH-2 -: MAN_BITS]};

  assign round_sticky[1] = norm_val[INT_WIDTH-2-MAN_BITS];
  assign round_sticky[0] = |norm_val[INT_WIDTH-3-MAN_BITS:0];

  // msb of pre_round is zero, so the sum never carries out
  cast_rounder u_rounder (
    .abs_value_i    (pre_round),
    .sign_i         (int_sign),
    .round_sticky_i (round_sticky),
    .rnd_mode_i     (rnd_mode_i),
    .abs_rounded_o  (rounded_abs),
    .carry_o        ()
  );

  // zero has no leading one, force +0
  assign result_o = val_zero ? '0 : {int_sign, rounded_abs[FP_WIDTH-2:0]};
  assign nx_o     = |round_sticky;

endmodule

`default_nettype wire

// File: verilog/cast_op_pkg.sv
// ----------------------------
// cast operation package
// opcodes and IEEE rounding modes
// ----------------------------

`default_nettype none

package cast_op_pkg;

  // ----------------------------
  // opcodes
  // ----------------------------
  typedef enum logic {
    OP_F2I = 1'b0, // fp32 -> int32
    OP_I2F = 1'b1  // int32 -> fp32
  } cast_op_e;

  // ----------------------------
  // rounding modes, riscv frm encoding
  // ----------------------------
  // codes 5..7 fall back to RNE in the rounder
  typedef enum logic [2:0] {
    RNE = 3'd0, // nearest, ties to even
    RTZ = 3'd1, // toward zero
    RDN = 3'd2, // toward -inf
    RUP = 3'd3, // toward +inf
    RMM = 3'd4  // nearest, ties away from zero
  } round_mode_e;

endpackage

`default_nettype wire

// File: verilog/cast_result_stage.sv
// ----------------------------
// cast result stage
// picks the converter result by opcode and holds
// it in one output register behind valid/ready
// ----------------------------

`default_nettype none

module cast_result_stage
  import cast_fmt_pkg::*;
  import cast_op_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  cast_op_e             op_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic [INT_WIDTH-1:0] f2i_result_i,
  input  logic                 f2i_nv_i,
  input  logic                 f2i_nx_i,
  input  logic [FP_WIDTH-1:0]  i2f_result_i,
  input  logic                 i2f_nx_i,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic [FP_WIDTH-1:0]  result_o,
  output logic                 flag_nv_o,
  output logic                 flag_nx_o
);

  logic                in_xfer;    // input handshake this cycle
  logic [FP_WIDTH-1:0] sel_result;
  logic                sel_nv;
  logic                sel_nx;

  // ----------------------------
  // handshake
  // ----------------------------
  assign in_ready_o = ~out_valid_o | out_ready_i; // empty, or draining now
  assign in_xfer    = in_valid_i & in_ready_o;

  // ----------------------------
  // result select
  // ----------------------------
  always_comb begin
    unique case (op_i)
      OP_I2F: begin
        sel_result = i2f_result_i;
        sel_nv     = 1'b0; // i2f on 32 bits is never invalid
        sel_nx     = i2f_nx_i;
      end
      default: begin
        sel_result = f2i_result_i;
        sel_nv     = f2i_nv_i;
        sel_nx     = f2i_nx_i;
      end
    endcase
  end

  // ----------------------------
  // output register
  // ----------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      out_valid_o <= in_valid_i; // refill or go empty
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      result_o  <= '0;
      flag_nv_o <= 1'b0;
      flag_nx_o <= 1'b0;
    end else if (in_xfer) begin
      result_o  <= sel_result;
      flag_nv_o <= sel_nv;
      flag_nx_o <= sel_nx;
    end
  end

endmodule

`default_nettype wire

// File: verilog/cast_rounder.sv
// ----------------------------
// cast rounder
// adds one ulp to a magnitude according to
// rounding mode, sign and round/sticky bits
// ----------------------------

`default_nettype none

module cast_rounder
  import cast_fmt_pkg::*;
  import cast_op_pkg::*;
(
  input  logic [INT_WIDTH-1:0] abs_value_i,    // unrounded magnitude
  input  logic                 sign_i,         // sign of the final value
  input  logic [1:0]           round_sticky_i, // [1] round, [0] sticky
  input  round_mode_e          rnd_mode_i,
  output logic [INT_WIDTH-1:0] abs_rounded_o,
  output logic                 carry_o         // wrapped past all ones
);

  logic round_up;
  logic inexact;

  assign inexact = |round_sticky_i;

  // ----------------------------
  // rounding decision
  // ----------------------------
  always_comb begin
    unique case (rnd_mode_i)
      RTZ: begin
        round_up = 1'b0; // truncate
      end
      RDN: begin
        round_up = inexact & sign_i; // away from zero only when negative
      end
      RUP: begin
        round_up = inexact & ~sign_i;
      end
      RMM: begin
        round_up = round_sticky_i[1]; // tie goes up in magnitude
      end
      default: begin
        // RNE and the unused codes
        // above half, or exact tie with odd lsb
        round_up = round_sticky_i[1] & (round_sticky_i[0] | abs_value_i[0]);
      end
    endcase
  end

  // mantissa overflow of fp values carries into the exponent by itself
  assign {carry_o, abs_rounded_o} = {1'b0, abs_value_i} + (INT_WIDTH + 1)'(round_up);

endmodule

`default_nettype wire

// File: verilog/cast_unit_top.sv
// ----------------------------
// FP32/INT32 cast unit
// both converters work on the same operand,
// one registered result per accepted input
// ----------------------------

`default_nettype none

module cast_unit_top
  import cast_op_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic [31:0] operand_i,      // fp32 or int32
  input  cast_op_e    op_i,
  input  logic        int_unsigned_i, // integer side unsigned
  input  round_mode_e rnd_mode_i,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  output logic        out_valid_o,
  input  logic        out_ready_i,
  output logic [31:0] result_o,
  output logic        flag_nv_o,
  output logic        flag_nx_o
);

  logic [31:0] f2i_result;
  logic        f2i_nv, f2i_nx;
  logic [31:0] i2f_result;
  logic        i2f_nx;

  cast_f2i u_f2i (
    .operand_i      (operand_i),
    .int_unsigned_i (int_unsigned_i),
    .rnd_mode_i     (rnd_mode_i),
    .result_o       (f2i_result),
    .nv_o           (f2i_nv),
    .nx_o           (f2i_nx)
  );

  cast_i2f u_i2f (
    .operand_i      (operand_i),
    .int_unsigned_i (int_unsigned_i),
    .rnd_mode_i     (rnd_mode_i),
    .result_o       (i2f_result),
    .nx_o           (i2f_nx)
  );

  // register stage, one item in flight
  cast_result_stage u_result_stage (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .op_i         (op_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .f2i_result_i (f2i_result),
    .f2i_nv_i     (f2i_nv),
    .f2i_nx_i     (f2i_nx),
    .i2f_result_i (i2f_result),
    .i2f_nx_i     (i2f_nx),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .result_o     (result_o),
    .flag_nv_o    (flag_nv_o),
    .flag_nx_o    (flag_nx_o)
  );

endmodule

`default_nettype wire
